/* common/pio_pkg.sv */
package pio_pkg;

  localparam int PIO_IMEM_DEPTH = 32; // Fixed by 5-bit address field

  // Host command codes
  typedef enum logic [3:0] {
    ACT_NOP         = 4'd0,
    ACT_WRITE_INSTR = 4'd1,
    ACT_SET_WRAP    = 4'd2,
    ACT_POP_RX      = 4'd3,
    ACT_PUSH_TX     = 4'd4,
    ACT_CONFIG_PINS = 4'd5,
    ACT_ENABLE      = 4'd6,
    ACT_CLKDIV      = 4'd7
  } pio_action_e;

  typedef enum logic [2:0] {
    OP_JMP      = 3'd0,
    OP_WAIT     = 3'd1, // No-op
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,
    OP_MOV      = 3'd5, // No-op
    OP_IRQ      = 3'd6, // No-op
    OP_SET      = 3'd7
  } pio_opcode_e;

  typedef enum logic [2:0] {
    COND_ALWAYS   = 3'd0,
    COND_NOT_X    = 3'd1,
    COND_X_DEC    = 3'd2,
    COND_NOT_Y    = 3'd3,
    COND_Y_DEC    = 3'd4,
    COND_PIN      = 3'd6,
    COND_NOT_OSRE = 3'd7  // OSR not yet shifted empty
  } pio_jmp_cond_e;

  // Source of IN, destination of OUT and SET
  typedef enum logic [2:0] {
    DEST_PINS    = 3'd0,
    DEST_X       = 3'd1,
    DEST_Y       = 3'd2,
    DEST_PINDIRS = 3'd4
  } pio_dest_e;

  typedef struct packed {
    pio_opcode_e opcode;
    logic [4:0]  delay;
    logic [2:0]  arg;  // Condition, dest, or pull flag in bit 2
    logic [4:0]  data; // Address, bit count or SET value
  } pio_instr_t;

  typedef struct packed {
    logic [4:0] out_base;
    logic [5:0] out_count;
    logic [4:0] set_base;
    logic [2:0] set_count;
    logic [4:0] in_base;
    logic [4:0] jmp_pin;
  } pio_pin_cfg_t;

  typedef struct packed {
    pio_pin_cfg_t pins;
    logic [15:0]  div;
    logic [4:0]   wrap_start;
    logic [4:0]   wrap_end;
  } pio_sm_cfg_t;

  typedef struct packed {
    logic [31:0] out;
    logic [31:0] dir;
    logic [31:0] own;
  } pio_gpio_t;

endpackage

/* logic/pio_fifo.sv */
`timescale 1ns/100ps

module pio_fifo #(
  parameter int DEPTH = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic [31:0] wdata,
  input  logic        pop,
  output logic [31:0] rdata,
  output logic        empty,
  output logic        full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] wr_ptr, rd_ptr;
  logic [AW:0]   count;
  logic          do_push, do_pop;

  assign empty   = (count == '0);
  assign full    = (count == DEPTH);
  assign do_push = push && !full;  // Dropped when full
  assign do_pop  = pop && !empty;
  assign rdata   = mem[rd_ptr];    // Head word

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
    end
  end

endmodule

/* logic/pio_output.sv */
`timescale 1ns/100ps

module pio_output import pio_pkg::*; #(
  parameter int NUM_SM = 4
) (
  input  pio_gpio_t         gpio [NUM_SM],
  input  logic [31:0]       rx_rdata [NUM_SM],
  input  logic [NUM_SM-1:0] rx_empty,
  input  logic [NUM_SM-1:0] tx_empty,
  input  logic [NUM_SM-1:0] enable,
  input  logic [1:0]        mindex,
  output logic [31:0]       gpio_out,
  output logic [31:0]       gpio_dir,
  output logic [31:0]       dout,
  output logic              irq0,
  output logic              irq1
);

  always_comb begin
    gpio_out = '0;
    gpio_dir = '0;
    dout     = '0;
    // Later machines override earlier ones on shared pins
    for (int i = 0; i < NUM_SM; i++) begin
      gpio_out = (gpio_out & ~gpio[i].own) | (gpio[i].out & gpio[i].own);
      gpio_dir = (gpio_dir & ~gpio[i].own) | (gpio[i].dir & gpio[i].own);
      if (mindex == i && !rx_empty[i]) begin
        dout = rx_rdata[i];
      end
    end
  end

  assign irq0 = ~&rx_empty;            // Data waiting for host
  assign irq1 = |(tx_empty & enable);  // Running machine wants data

endmodule

/* pio/pio_control.sv */
`timescale 1ns/100ps

module pio_control import pio_pkg::*; #(
  parameter int NUM_SM = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  pio_action_e       action,
  input  logic [1:0]        mindex,
  input  logic [4:0]        index,
  input  logic [31:0]       din,
  input  logic [4:0]        pc [NUM_SM],
  output pio_instr_t        instr [NUM_SM],
  output pio_sm_cfg_t       sm_cfg [NUM_SM],
  output logic [NUM_SM-1:0] enable,
  output logic [NUM_SM-1:0] tx_push,
  output logic [NUM_SM-1:0] rx_pop
);

  pio_instr_t imem [PIO_IMEM_DEPTH]; // Shared by all machines

  always_ff @(posedge clk) begin
    if (action == ACT_WRITE_INSTR) begin
      imem[index] <= pio_instr_t'(din[15:0]);
    end
  end

  // One read port per machine, same cycle
  always_comb begin
    for (int i = 0; i < NUM_SM; i++) begin
      instr[i] = imem[pc[i]];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      enable <= '0;
      for (int i = 0; i < NUM_SM; i++) begin
        sm_cfg[i]                <= '0;
        sm_cfg[i].pins.set_count <= 3'd1;
      end
    end else begin
      if (action == ACT_ENABLE) begin
        enable <= din[NUM_SM-1:0];
      end
      for (int i = 0; i < NUM_SM; i++) begin
        if (mindex == i) begin
          case (action)
            ACT_SET_WRAP: begin
              sm_cfg[i].wrap_end   <= index;
              sm_cfg[i].wrap_start <= din[4:0];
            end
            ACT_CONFIG_PINS: sm_cfg[i].pins <= pio_pin_cfg_t'(din[28:0]);
            ACT_CLKDIV:      sm_cfg[i].div  <= din[15:0];
            default: ;
          endcase
        end
      end
    end
  end

  // FIFO strobes, dropped by the FIFO when full or empty
  always_comb begin
    for (int i = 0; i < NUM_SM; i++) begin
      tx_push[i] = (action == ACT_PUSH_TX) && (mindex == i);
      rx_pop[i]  = (action == ACT_POP_RX) && (mindex == i);
    end
  end

  // A machine-addressed command must name a machine that exists
  a_mindex_range: assert property (
    @(posedge clk) disable iff (reset)
    action inside {ACT_SET_WRAP, ACT_POP_RX, ACT_PUSH_TX, ACT_CONFIG_PINS, ACT_CLKDIV}
      |-> (mindex < NUM_SM)
  ) else $error("pio_control: mindex %0d out of range", mindex);

endmodule

/* pio/pio_machine.sv */
`timescale 1ns/100ps

module pio_machine import pio_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  pio_sm_cfg_t cfg,
  input  logic [31:0] gpio_in,
  output logic [4:0]  pc,
  input  pio_instr_t  instr,
  input  logic [31:0] tx_rdata,
  input  logic        tx_empty,
  output logic        tx_pop,
  output logic [31:0] rx_wdata,
  input  logic        rx_full,
  output logic        rx_push,
  output pio_gpio_t   gpio
);

  typedef enum logic [1:0] {
    DISABLED,
    RUN,
    DELAY
  } sm_state_e;

  sm_state_e   state;
  logic [15:0] div_cnt;
  logic [4:0]  delay_cnt;
  logic [5:0]  osr_cnt;  // Bits shifted out since last PULL
  logic [31:0] x, y, isr, osr;

  logic        tick, exec, stall, jump, jmp_cond;
  logic        is_pull, is_push;
  logic [5:0]  bit_cnt;
  logic [6:0]  osr_sum;
  logic [31:0] out_data, in_data;
  logic [31:0] pin_val, pin_mask;
  logic        wr_pins, wr_dirs;
  pio_dest_e   dest;

  function automatic logic [31:0] low_mask(input logic [5:0] n);
    return ~(32'hffff_ffff << n);
  endfunction

  function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] s);
    logic [63:0] t;
    t = {v, v} << s;
    return t[63:32];
  endfunction

  function automatic logic [31:0] rotr(input logic [31:0] v, input logic [4:0] s);
    logic [63:0] t;
    t = {v, v} >> s;
    return t[31:0];
  endfunction

  assign tick    = enable && (state != DISABLED) && (div_cnt >= cfg.div);
  assign exec    = tick && (state == RUN);
  assign dest    = pio_dest_e'(instr.arg);
  assign bit_cnt = (instr.data == 5'd0) ? 6'd32 : {1'b0, instr.data};
  assign is_pull = (instr.opcode == OP_PUSHPULL) && instr.arg[2];
  assign is_push = (instr.opcode == OP_PUSHPULL) && !instr.arg[2];
  assign stall   = (is_pull && tx_empty) || (is_push && rx_full); // Blocking retry
  assign tx_pop  = exec && is_pull && !tx_empty;
  assign rx_push = exec && is_push && !rx_full;
  assign rx_wdata = isr;

  assign out_data = osr & low_mask(bit_cnt);
  assign osr_sum  = osr_cnt + bit_cnt;

  always_comb begin
    case (pio_jmp_cond_e'(instr.arg))
      COND_ALWAYS:   jmp_cond = 1'b1;
      COND_NOT_X:    jmp_cond = (x == '0);
      COND_X_DEC:    jmp_cond = (x != '0);
      COND_NOT_Y:    jmp_cond = (y == '0);
      COND_Y_DEC:    jmp_cond = (y != '0);
      COND_PIN:      jmp_cond = gpio_in[cfg.pins.jmp_pin];
      COND_NOT_OSRE: jmp_cond = (osr_cnt < 6'd32);
      default:       jmp_cond = 1'b0;
    endcase
  end
  assign jump = (instr.opcode == OP_JMP) && jmp_cond;

  always_comb begin
    case (dest)
      DEST_PINS: in_data = rotr(gpio_in, cfg.pins.in_base);
      DEST_X:    in_data = x;
      DEST_Y:    in_data = y;
      default:   in_data = '0;
    endcase
  end

  // Pin field placement, wrapping past bit 31
  always_comb begin
    if (instr.opcode == OP_OUT) begin
      pin_val  = rotl(out_data, cfg.pins.out_base);
      pin_mask = rotl(low_mask(cfg.pins.out_count), cfg.pins.out_base);
    end else begin
      pin_val  = rotl({27'd0, instr.data}, cfg.pins.set_base);
      pin_mask = rotl(low_mask({3'd0, cfg.pins.set_count}), cfg.pins.set_base);
    end
    wr_pins = exec && (instr.opcode inside {OP_OUT, OP_SET}) && (dest == DEST_PINS);
    wr_dirs = exec && (instr.opcode inside {OP_OUT, OP_SET}) && (dest == DEST_PINDIRS);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= DISABLED;
      pc        <= '0;
      div_cnt   <= '0;
      delay_cnt <= '0;
      osr_cnt   <= 6'd32;
      gpio      <= '0;
    end else begin
      case (state)
        DISABLED: begin
          if (enable) begin
            state     <= RUN;
            pc        <= cfg.wrap_start;
            div_cnt   <= '0;
            delay_cnt <= '0;
          end
        end
        default: begin
          if (!enable) begin
            state <= DISABLED;
          end else begin
            div_cnt <= tick ? '0 : div_cnt + 16'd1;
            if (tick && state == DELAY) begin
              delay_cnt <= delay_cnt - 5'd1;
              if (delay_cnt == 5'd1) state <= RUN;
            end else if (exec && !stall) begin
              if (jump) pc <= instr.data;
              else if (pc == cfg.wrap_end) pc <= cfg.wrap_start;
              else pc <= pc + 5'd1;
              if (instr.delay != '0) begin
                state     <= DELAY;
                delay_cnt <= instr.delay;
              end
            end
          end
        end
      endcase
      if (exec && instr.opcode == OP_OUT) begin
        osr_cnt <= (osr_sum > 7'd32) ? 6'd32 : osr_sum[5:0];
      end
      if (tx_pop) osr_cnt <= '0;
      if (wr_pins) begin
        gpio.out <= (gpio.out & ~pin_mask) | (pin_val & pin_mask);
        gpio.own <= gpio.own | pin_mask;
      end
      if (wr_dirs) begin
        gpio.dir <= (gpio.dir & ~pin_mask) | (pin_val & pin_mask);
        gpio.own <= gpio.own | pin_mask;
      end
    end
  end

  // Data path registers
  always_ff @(posedge clk) begin
    if (exec) begin
      case (instr.opcode)
        OP_JMP: begin
          if (pio_jmp_cond_e'(instr.arg) == COND_X_DEC) x <= x - 32'd1;
          if (pio_jmp_cond_e'(instr.arg) == COND_Y_DEC) y <= y - 32'd1;
        end
        OP_IN:  isr <= (isr << bit_cnt) | (in_data & low_mask(bit_cnt));
        OP_OUT: begin
          osr <= osr >> bit_cnt;
          if (dest == DEST_X) x <= out_data;
          if (dest == DEST_Y) y <= out_data;
        end
        OP_PUSHPULL: begin
          if (tx_pop) osr <= tx_rdata;
          if (rx_push) isr <= '0;
        end
        OP_SET: begin
          if (dest == DEST_X) x <= {27'd0, instr.data};
          if (dest == DEST_Y) y <= {27'd0, instr.data};
        end
        default: ;
      endcase
    end
  end

  // The FIFOs flag their own limits
  a_fifo_limits: assert property (
    @(posedge clk) disable iff (reset)
    !(tx_pop && tx_empty) && !(rx_push && rx_full)
  ) else $error("pio_machine: FIFO strobe against flag");

endmodule

/* pio/pio.sv */
`timescale 1ns/100ps

module pio import pio_pkg::*; #(
  parameter int NUM_SM     = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [1:0]  mindex,
  input  logic [31:0] din,
  input  logic [4:0]  index,
  input  pio_action_e action,
  output logic [31:0] dout,
  input  logic [31:0] gpio_in,
  output logic [31:0] gpio_out,
  output logic [31:0] gpio_dir,
  output logic        irq0,
  output logic        irq1
);

  pio_sm_cfg_t       sm_cfg [NUM_SM];
  pio_instr_t        instr [NUM_SM];
  pio_gpio_t         gpio [NUM_SM];
  logic [4:0]        pc [NUM_SM];
  logic [31:0]       tx_rdata [NUM_SM];
  logic [31:0]       rx_wdata [NUM_SM];
  logic [31:0]       rx_rdata [NUM_SM];
  logic [NUM_SM-1:0] enable;
  logic [NUM_SM-1:0] tx_push, tx_pop, tx_empty;
  logic [NUM_SM-1:0] rx_push, rx_pop, rx_empty, rx_full;

  pio_control #(.NUM_SM(NUM_SM)) control_inst (
    .clk     (clk),
    .reset   (reset),
    .action  (action),
    .mindex  (mindex),
    .index   (index),
    .din     (din),
    .pc      (pc),
    .instr   (instr),
    .sm_cfg  (sm_cfg),
    .enable  (enable),
    .tx_push (tx_push),
    .rx_pop  (rx_pop)
  );

  for (genvar i = 0; i < NUM_SM; i++) begin : g_sm
    pio_machine machine_inst (
      .clk      (clk),
      .reset    (reset),
      .enable   (enable[i]),
      .cfg      (sm_cfg[i]),
      .gpio_in  (gpio_in),
      .pc       (pc[i]),
      .instr    (instr[i]),
      .tx_rdata (tx_rdata[i]),
      .tx_empty (tx_empty[i]),
      .tx_pop   (tx_pop[i]),
      .rx_wdata (rx_wdata[i]),
      .rx_full  (rx_full[i]),
      .rx_push  (rx_push[i]),
      .gpio     (gpio[i])
    );

    // Host to machine
    pio_fifo #(.DEPTH(FIFO_DEPTH)) tx_fifo_inst (
      .clk(clk), .reset(reset), .push(tx_push[i]), .wdata(din), .pop(tx_pop[i]),
      .rdata(tx_rdata[i]), .empty(tx_empty[i]), .full()
    );

    // Machine to host
    pio_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo_inst (
      .clk(clk), .reset(reset), .push(rx_push[i]), .wdata(rx_wdata[i]), .pop(rx_pop[i]),
      .rdata(rx_rdata[i]), .empty(rx_empty[i]), .full(rx_full[i])
    );
  end

  pio_output #(.NUM_SM(NUM_SM)) output_inst (
    .gpio(gpio), .rx_rdata(rx_rdata), .rx_empty(rx_empty), .tx_empty(tx_empty),
    .enable(enable), .mindex(mindex), .gpio_out(gpio_out), .gpio_dir(gpio_dir),
    .dout(dout), .irq0(irq0), .irq1(irq1)
  );

endmodule

/* verif/pio_tb.sv */
`timescale 1ns/100ps

module pio_tb import pio_pkg::*; ();

  localparam int NUM_SM       = 4;
  localparam int FIFO_DEPTH   = 4;
  localparam int CLK_PERIOD   = 40;
  localparam int WAIT_LIMIT   = 400;  // Cycles per wait for the DUT
  localparam int PLANNED_CMDS = 90;
  localparam int WATCHDOG_NS  = (PLANNED_CMDS * 400 + 500) * CLK_PERIOD;

  logic        clk, reset;
  logic [1:0]  mindex;
  logic [31:0] din, dout, gpio_in, gpio_out, gpio_dir;
  logic [4:0]  index;
  pio_action_e action;
  logic        irq0, irq1;

  // Scoreboard and check strobes
  logic [31:0] exp_dout, exp_gpio_out, exp_gpio_dir;
  logic        exp_irq0, exp_irq1;
  logic        chk_dout, chk_pins, chk_irq, before_enable;
  logic [31:0] rng;
  logic [31:0] fill_q [$];
  int          errors, checks;

  pio #(.NUM_SM(NUM_SM), .FIFO_DEPTH(FIFO_DEPTH)) pio_inst (
    .clk(clk), .reset(reset), .mindex(mindex), .din(din), .index(index), .action(action),
    .dout(dout), .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_dir(gpio_dir),
    .irq0(irq0), .irq1(irq1)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: run still busy after %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  a_idle_zero: assert property (@(posedge clk) disable iff (reset || !before_enable)
    (gpio_out == '0) && (gpio_dir == '0) && (dout == '0) && !irq0 && !irq1)
  else begin
    errors++;
    $display("FAILED idle outputs: gpio_out=%h gpio_dir=%h dout=%h irq0=%h irq1=%h",
      $sampled(gpio_out), $sampled(gpio_dir), $sampled(dout), $sampled(irq0), $sampled(irq1));
  end

  a_dout: assert property (@(posedge clk) disable iff (reset) chk_dout |-> dout == exp_dout)
  else begin
    errors++;
    $display("FAILED dout: got %h expected %h", $sampled(dout), exp_dout);
  end

  a_pins: assert property (@(posedge clk) disable iff (reset)
    chk_pins |-> (gpio_out == exp_gpio_out) && (gpio_dir == exp_gpio_dir))
  else begin
    errors++;
    $display("FAILED gpio_out/gpio_dir: got %h/%h expected %h/%h",
      $sampled(gpio_out), $sampled(gpio_dir), exp_gpio_out, exp_gpio_dir);
  end

  a_irq: assert property (@(posedge clk) disable iff (reset)
    chk_irq |-> (irq0 == exp_irq0) && (irq1 == exp_irq1))
  else begin
    errors++;
    $display("FAILED irq0/irq1: got %h/%h expected %h/%h",
      $sampled(irq0), $sampled(irq1), exp_irq0, exp_irq1);
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] encode(input pio_opcode_e op, input logic [4:0] delay,
                                         input logic [2:0] arg, input logic [4:0] data);
    return {16'd0, op, delay, arg, data};
  endfunction

  function automatic logic [31:0] pin_cfg(input logic [4:0] set_base,
                                          input logic [2:0] set_count, input logic [4:0] jmp_pin);
    return {3'd0, 5'd0, 6'd0, set_base, set_count, 5'd0, jmp_pin};
  endfunction

  // Later writer wins on the field it covers
  function automatic logic [31:0] overlay_field(input logic [31:0] word, input logic [31:0] val,
                                                input int base, input int count);
    logic [31:0] mask;
    mask = ((32'd1 << count) - 32'd1) << base;
    return (word & ~mask) | ((val << base) & mask);
  endfunction

  task automatic send(input pio_action_e act, input logic [1:0] m, input logic [4:0] idx,
                      input logic [31:0] d);
    @(posedge clk);
    #2;
    action = act;
    mindex = m;
    index  = idx;
    din    = d;
    @(posedge clk);
    #2;
    action = ACT_NOP;
  endtask

  task automatic write_instr(input logic [4:0] addr, input logic [31:0] word);
    send(ACT_WRITE_INSTR, 2'd0, addr, word);
  endtask

  task automatic set_program(input logic [4:0] base, input logic [4:0] value);
    write_instr(base, encode(OP_SET, 5'd0, DEST_PINDIRS, 5'd31));
    write_instr(base + 5'd1, encode(OP_SET, 5'd0, DEST_PINS, value));
    write_instr(base + 5'd2, encode(OP_PUSHPULL, 5'd0, 3'b000, 5'd0));
    write_instr(base + 5'd3, encode(OP_JMP, 5'd0, COND_ALWAYS, base + 5'd3)); // Park
  endtask

  task automatic load_program();
    write_instr(5'd0, encode(OP_PUSHPULL, 5'd0, 3'b100, 5'd0)); // PULL
    write_instr(5'd1, encode(OP_OUT, 5'd3, DEST_X, 5'd0));
    write_instr(5'd2, encode(OP_IN, 5'd0, DEST_X, 5'd0));
    write_instr(5'd3, encode(OP_PUSHPULL, 5'd0, 3'b000, 5'd0)); // PUSH
    set_program(5'd4, 5'd21);
    set_program(5'd8, 5'd10);
    set_program(5'd12, 5'd19);
    write_instr(5'd16, encode(OP_SET, 5'd0, DEST_X, 5'd3));
    write_instr(5'd17, encode(OP_JMP, 5'd0, COND_X_DEC, 5'd17));
    write_instr(5'd18, encode(OP_IN, 5'd0, DEST_X, 5'd0));
    write_instr(5'd19, encode(OP_PUSHPULL, 5'd0, 3'b000, 5'd0));
    write_instr(5'd20, encode(OP_JMP, 5'd0, COND_ALWAYS, 5'd20));
    write_instr(5'd21, encode(OP_JMP, 5'd0, COND_PIN, 5'd24));
    write_instr(5'd22, encode(OP_SET, 5'd0, DEST_Y, 5'd1)); // Branch not taken
    write_instr(5'd23, encode(OP_JMP, 5'd0, COND_ALWAYS, 5'd25));
    write_instr(5'd24, encode(OP_SET, 5'd0, DEST_Y, 5'd7));
    write_instr(5'd25, encode(OP_IN, 5'd0, DEST_Y, 5'd0));
    write_instr(5'd26, encode(OP_PUSHPULL, 5'd0, 3'b000, 5'd0));
    write_instr(5'd27, encode(OP_JMP, 5'd0, COND_ALWAYS, 5'd27));
  endtask

  task automatic wait_irq(input bit line);
    int n;
    n = 0;
    while (((line ? irq1 : irq0) !== 1'b1) && (n < WAIT_LIMIT)) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (n == WAIT_LIMIT) begin
      errors++;
      $display("Timed out after %0d cycles waiting for irq%0d", n, line);
    end
  endtask

  task automatic pop_check(input logic [1:0] m, input logic [31:0] expected);
    @(posedge clk);
    #2;
    action   = ACT_POP_RX;
    mindex   = m;
    exp_dout = expected;
    chk_dout = 1'b1;
    checks++;
    @(posedge clk);
    #2;
    action   = ACT_NOP;
    chk_dout = 1'b0;
  endtask

  task automatic check_irq(input bit e0, input bit e1);
    @(posedge clk);
    #2;
    exp_irq0 = e0;
    exp_irq1 = e1;
    chk_irq  = 1'b1;
    checks++;
    @(posedge clk);
    #2;
    chk_irq = 1'b0;
  endtask

  task automatic check_pins(input logic [31:0] e_out, input logic [31:0] e_dir);
    @(posedge clk);
    #2;
    exp_gpio_out = e_out;
    exp_gpio_dir = e_dir;
    chk_pins     = 1'b1;
    checks++;
    @(posedge clk);
    #2;
    chk_pins = 1'b0;
  endtask

  task automatic loopback(input logic [1:0] m, input int n);
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
      rng = xorshift(rng);
      w   = rng;
      send(ACT_PUSH_TX, m, 5'd0, w);
      wait_irq(1'b0);
      pop_check(m, w);
    end
  endtask

  initial begin
    logic [31:0] w, e_out, e_dir;
    reset         = 1'b1;
    action        = ACT_NOP;
    mindex        = 2'd0;
    index         = 5'd0;
    din           = '0;
    gpio_in       = '0;
    exp_dout      = '0;
    exp_gpio_out  = '0;
    exp_gpio_dir  = '0;
    exp_irq0      = 1'b0;
    exp_irq1      = 1'b0;
    chk_dout      = 1'b0;
    chk_pins      = 1'b0;
    chk_irq       = 1'b0;
    before_enable = 1'b1;
    rng           = 32'd10459;
    errors        = 0;
    checks        = 0;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;

    load_program();
    send(ACT_SET_WRAP, 2'd0, 5'd3, 32'd0);
    before_enable = 1'b0;
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h1);
    check_irq(1'b0, 1'b1);
    loopback(2'd0, 6);
    send(ACT_SET_WRAP, 2'd1, 5'd3, 32'd0);
    send(ACT_CLKDIV, 2'd1, 5'd0, 32'd3);
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h2);
    loopback(2'd1, 6);

    // Overfill tx of a stopped machine
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h0);
    for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
      rng = xorshift(rng);
      w   = rng;
      send(ACT_PUSH_TX, 2'd0, 5'd0, w);
      if (fill_q.size() < FIFO_DEPTH) fill_q.push_back(w); // Full FIFO drops the push
    end
    check_irq(1'b0, 1'b0);
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h1);
    wait_irq(1'b1);
    check_irq(1'b1, 1'b1);
    while (fill_q.size() > 0) begin
      wait_irq(1'b0);
      pop_check(2'd0, fill_q.pop_front());
    end
    check_irq(1'b0, 1'b1);
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h0);

    send(ACT_CONFIG_PINS, 2'd1, 5'd0, pin_cfg(5'd4, 3'd5, 5'd0));
    send(ACT_SET_WRAP, 2'd1, 5'd7, 32'd4);
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h2);
    wait_irq(1'b0);
    send(ACT_POP_RX, 2'd1, 5'd0, 32'd0);
    e_out = overlay_field(32'd0, 32'd21, 4, 5);
    e_dir = overlay_field(32'd0, 32'd31, 4, 5);
    check_pins(e_out, e_dir);

    // Machines 0 and 2 overlap on bits 18 to 20
    send(ACT_CONFIG_PINS, 2'd0, 5'd0, pin_cfg(5'd16, 3'd5, 5'd0));
    send(ACT_SET_WRAP, 2'd0, 5'd11, 32'd8);
    send(ACT_CONFIG_PINS, 2'd2, 5'd0, pin_cfg(5'd18, 3'd5, 5'd0));
    send(ACT_SET_WRAP, 2'd2, 5'd15, 32'd12);
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h1);
    wait_irq(1'b0);
    send(ACT_POP_RX, 2'd0, 5'd0, 32'd0);
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h5);
    wait_irq(1'b0);
    send(ACT_POP_RX, 2'd2, 5'd0, 32'd0);
    e_out = overlay_field(overlay_field(e_out, 32'd10, 16, 5), 32'd19, 18, 5);
    e_dir = overlay_field(overlay_field(e_dir, 32'd31, 16, 5), 32'd31, 18, 5);
    check_pins(e_out, e_dir);

    // X counts 3 down past zero
    send(ACT_SET_WRAP, 2'd3, 5'd31, 32'd16);
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h8);
    wait_irq(1'b0);
    pop_check(2'd3, 32'hffff_ffff);
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h0);
    send(ACT_CONFIG_PINS, 2'd3, 5'd0, pin_cfg(5'd0, 3'd1, 5'd9));
    gpio_in = 32'h0000_0200;  // jmp_pin high
    send(ACT_SET_WRAP, 2'd3, 5'd31, 32'd21);
    send(ACT_ENABLE, 2'd0, 5'd0, 32'h8);
    wait_irq(1'b0);
    pop_check(2'd3, 32'd7);

    repeat (2) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
common/pio_pkg.sv
logic/pio_fifo.sv
logic/pio_output.sv
pio/pio_control.sv
pio/pio_machine.sv
pio/pio.sv
verif/pio_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module pio_tb -f build.f -o sim_pio

# The log decides the result, so a non-zero exit of the run is recorded there
./obj_dir/sim_pio > sim.log 2>&1 || true
cat sim.log

if grep -q '>>> FAIL' sim.log || ! grep -q '>>> PASS' sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
